/* verilog/walk_macros.svh */
`ifndef WALK_MACROS_SVH
`define WALK_MACROS_SVH

// translation requesters: fetch, load, store
`define NUM_RQS 3

// page table RAM depth in 32-bit words (16 KiB)
`define PTE_RAM_WORDS 4096

// byte address falls inside the page table RAM
`define IS_LEGAL_ADDR(a) ((((a) >> 14) == 32'd0))

`endif

/* verilog/walkPkg.sv */
`default_nettype none

`include "walk_macros.svh"

package walkPkg;

    typedef logic [31:0] VirtAddr;
    // physical addresses are cut down to 32 bits
    typedef logic [31:0] PhysAddr;
    typedef logic [21:0] Ppn;
    typedef logic [19:0] Vpn;
    typedef logic [31:0] Pte;
    typedef logic [1:0]  RqId;

    // one level request per requester, held until the matching result
    typedef struct packed {
        logic    valid;
        VirtAddr addr;
        Ppn      rootPpn;
    } PageWalkReq;

    typedef struct packed {
        logic valid;
        logic busy;
        RqId  rqId;
        logic pageFault;
        logic isSuperPage;
        Ppn   ppn;
        Vpn   vpn;
        // r, w, x from msb down
        logic [2:0] rwx;
        logic globl;
        logic user;
    } PageWalkRes;

    typedef struct packed {
        logic    valid;
        PhysAddr addr;
    } PwLoadReq;

    // identified by valid alone
    typedef struct packed {
        logic valid;
        Pte   result;
    } PwLoadRes;

    // fills the page table RAM from outside, addr is a word index
    typedef struct packed {
        logic                             en;
        logic [$clog2(`PTE_RAM_WORDS)-1:0] addr;
        Pte                               data;
    } PteWrite;

endpackage

`default_nettype wire

/* verilog/PteLoadPort.sv */
`default_nettype none
`timescale 1ns/10ps

`include "walk_macros.svh"

module PteLoadPort (
    input  wire               clk,
    input  wire               rst,
    input  walkPkg::PwLoadReq ldReq,
    output logic              ldStall,
    output walkPkg::PwLoadRes ldRes,
    input  walkPkg::PteWrite  pteWr
);
    import walkPkg::*;

    localparam int IDX_W = $clog2(`PTE_RAM_WORDS);

    Pte ram [`PTE_RAM_WORDS];

    logic             accept;
    logic             s1Valid;
    logic [IDX_W-1:0] s1Idx;

    // a write takes the port for the whole cycle
    assign ldStall = pteWr.en;
    assign accept = ldReq.valid && !ldStall;

    always_ff @(posedge clk) begin
        if (pteWr.en) begin
            ram[pteWr.addr] <= pteWr.data;
        end
    end

    // stage one: word index
    always_ff @(posedge clk) begin
        if (rst) begin
            s1Valid <= 1'b0;
        end else begin
            s1Valid <= accept;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            s1Idx <= ldReq.addr[IDX_W+1:2];
        end
    end

    // stage two: RAM data
    always_ff @(posedge clk) begin
        if (rst) begin
            ldRes.valid <= 1'b0;
        end else begin
            ldRes.valid <= s1Valid;
        end
    end

    always_ff @(posedge clk) begin
        if (s1Valid) begin
            ldRes.result <= ram[s1Idx];
        end
    end

endmodule

`default_nettype wire

/* verilog/PageWalker.sv */
`default_nettype none
`timescale 1ns/10ps

`include "walk_macros.svh"

module PageWalker #(
    parameter int NUM_RQS = `NUM_RQS
) (
    input  wire                 clk,
    input  wire                 rst,
    input  walkPkg::PageWalkReq rqs [NUM_RQS-1:0],
    output walkPkg::PageWalkRes res,
    input  wire                 ldStall,
    output walkPkg::PwLoadReq   ldReq,
    input  walkPkg::PwLoadRes   ldRes
);
    import walkPkg::*;

    typedef enum logic [0:0] {
        IDLE,
        WAIT_FOR_LOAD
    } WalkState;

    WalkState state;
    // 1 while reading the root table, 0 for the second level
    logic     level;
    VirtAddr  walkAddr;

    PageWalkReq selReq;
    RqId        selId;

    Pte      pte;
    PhysAddr nextAddr;
    logic    isPointer;

    logic       leafFault;
    logic [2:0] leafRwx;
    logic       leafGlobl;
    logic       leafUser;

    // highest index wins
    always_comb begin
        selReq = '0;
        selId = '0;
        for (int i = 0; i < NUM_RQS; i++) begin
            if (rqs[i].valid) begin
                selReq = rqs[i];
                selId = RqId'(i);
            end
        end
    end

    assign pte = ldRes.result;
    assign nextAddr = {pte[29:10], walkAddr[21:12], 2'b00};

    // a level-1 entry with only V set points to the next table
    assign isPointer = level && (pte[3:0] == 4'b0001) && (pte[31:30] == 2'b00)
        && `IS_LEGAL_ADDR(nextAddr);

    always_comb begin
        // invalid or not accessed
        leafFault = !pte[0] || !pte[6];

        // superpage must be aligned to 4 MiB
        if (level && pte[19:10] != 10'd0) begin
            leafFault = 1'b1;
        end

        case (pte[3:1])
            3'b000, 3'b010, 3'b110: leafFault = 1'b1;
            default: ;
        endcase

        leafRwx = 3'b000;
        leafGlobl = 1'b0;
        leafUser = 1'b0;
        if (!leafFault) begin
            // write only once the page is dirty
            leafRwx = {pte[1], pte[2] && pte[7], pte[3]};
            leafGlobl = pte[5];
            leafUser = pte[4];
        end
    end

    always_ff @(posedge clk) begin
        res.valid <= 1'b0;

        if (rst) begin
            state <= IDLE;
            ldReq.valid <= 1'b0;
            res.busy <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (selReq.valid) begin
                        state <= WAIT_FOR_LOAD;
                        level <= 1'b1;
                        walkAddr <= selReq.addr;
                        res.rqId <= selId;
                        res.busy <= 1'b1;
                        ldReq.valid <= 1'b1;
                        ldReq.addr <= {selReq.rootPpn[19:0], selReq.addr[31:22], 2'b00};
                    end
                end

                WAIT_FOR_LOAD: begin
                    if (ldReq.valid) begin
                        // hold the request until the port takes it
                        if (!ldStall) begin
                            ldReq.valid <= 1'b0;
                        end
                    end else if (ldRes.valid) begin
                        if (isPointer) begin
                            level <= 1'b0;
                            ldReq.valid <= 1'b1;
                            ldReq.addr <= nextAddr;
                        end else begin
                            state <= IDLE;
                            res.busy <= 1'b0;
                            res.valid <= 1'b1;
                            res.pageFault <= leafFault;
                            res.isSuperPage <= level;
                            res.ppn <= pte[31:10];
                            res.vpn <= walkAddr[31:12];
                            res.rwx <= leafRwx;
                            res.globl <= leafGlobl;
                            res.user <= leafUser;
                        end
                    end
                end

                default: state <= IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

/* verilog/PageWalkUnit.sv */
`default_nettype none
`timescale 1ns/10ps

`include "walk_macros.svh"

module PageWalkUnit #(
    parameter int NUM_RQS = `NUM_RQS
) (
    input  wire                 clk,
    input  wire                 rst,
    input  walkPkg::PageWalkReq rqs [NUM_RQS-1:0],
    output walkPkg::PageWalkRes res,
    input  walkPkg::PteWrite    pteWr
);
    import walkPkg::*;

    PwLoadReq ldReq;
    PwLoadRes ldRes;
    wire      ldStall;

    PageWalker #(
        .NUM_RQS (NUM_RQS)
    ) walker (
        .clk     (clk),
        .rst     (rst),
        .rqs     (rqs),
        .res     (res),
        .ldStall (ldStall),
        .ldReq   (ldReq),
        .ldRes   (ldRes)
    );

    // local page table RAM in place of the data cache
    PteLoadPort loadPort (
        .clk     (clk),
        .rst     (rst),
        .ldReq   (ldReq),
        .ldStall (ldStall),
        .ldRes   (ldRes),
        .pteWr   (pteWr)
    );

endmodule

`default_nettype wire

/* bench/PageWalkUnit_chk.sv */
`default_nettype none
`timescale 1ns/10ps

module PageWalkUnitChk (
    input wire                 clk,
    input wire                 rst,
    input walkPkg::PageWalkRes res,
    input walkPkg::PwLoadReq   ldReq,
    input wire                 ldStall,
    input walkPkg::PwLoadRes   ldRes
);
    import walkPkg::*;

    resultOneCycle: assert property (@(posedge clk) disable iff (rst)
        $past(res.valid) |-> !res.valid)
        else $error("result valid held for more than one cycle");

    // a stalled load keeps its request
    stallHold: assert property (@(posedge clk) disable iff (rst)
        $past(ldReq.valid && ldStall) |-> ldReq.valid && ldReq.addr == $past(ldReq.addr))
        else $error("load request changed while stalled");

    loadLatency: assert property (@(posedge clk) disable iff (rst)
        ldRes.valid == $past(ldReq.valid && !ldStall, 2))
        else $error("load result not two cycles after an accepted load");

    busyExclusive: assert property (@(posedge clk) disable iff (rst)
        !(res.busy && res.valid))
        else $error("busy and result valid high together");

endmodule

bind PageWalkUnit PageWalkUnitChk chk (
    .clk     (clk),
    .rst     (rst),
    .res     (res),
    .ldReq   (ldReq),
    .ldStall (ldStall),
    .ldRes   (ldRes)
);

`default_nettype wire

/* bench/PageWalkUnitTb.sv */
`default_nettype none
`timescale 1ns/10ps

`include "walk_macros.svh"

module PageWalkUnitTb;
    import walkPkg::*;

    typedef struct packed {
        logic [`NUM_RQS-1:0] mask;
        VirtAddr             va;
        Ppn                  rootPpn;
        Pte                  l1;
        Pte                  l0;
        logic                noise;
        logic                fault;
        logic                superPage;
        Ppn                  ppn;
        logic [2:0]          rwx;
        logic                globl;
        logic                user;
    } TestVec;

    localparam int NUM_TESTS = 15;
    localparam int TIMEOUT = 200;

    logic       clk;
    logic       rst;
    PageWalkReq rqs [`NUM_RQS-1:0];
    PageWalkRes res;
    PteWrite    pteWr;

    integer seed;
    int     errors;
    int     passed;
    int     failed;
    logic   aborted;

    // requests, PTEs and noise, then fault, super, ppn, rwx, globl, user
    TestVec tests [NUM_TESTS] = '{
        '{3'b001, 32'h0040_3000, 22'd1, 32'h0000_0801, 32'h048D_147B, 1'b0,
          1'b0, 1'b0, 22'h12345, 3'b101, 1'b1, 1'b1},
        '{3'b010, 32'h1234_5000, 22'd1, 32'h0000_0801, 32'h02AF_34C7, 1'b0,
          1'b0, 1'b0, 22'h0ABCD, 3'b110, 1'b0, 1'b0},
        // W without D
        '{3'b001, 32'h0080_1000, 22'd0, 32'h0000_0801, 32'h0001_084F, 1'b0,
          1'b0, 1'b0, 22'h00042, 3'b101, 1'b0, 1'b0},
        '{3'b001, 32'h0C00_0ABC, 22'd1, 32'h1230_006B, 32'h0000_0000, 1'b0,
          1'b0, 1'b1, 22'h48C00, 3'b101, 1'b1, 1'b0},
        // misaligned superpage
        '{3'b001, 32'h0C40_0000, 22'd1, 32'h1230_046B, 32'h0000_0000, 1'b0,
          1'b1, 1'b0, 22'h0, 3'b000, 1'b0, 1'b0},
        '{3'b001, 32'h0040_4000, 22'd1, 32'h0000_0801, 32'h0001_00CE, 1'b0,
          1'b1, 1'b0, 22'h0, 3'b000, 1'b0, 1'b0},
        '{3'b001, 32'h0040_5000, 22'd1, 32'h0000_0801, 32'h0001_548F, 1'b0,
          1'b1, 1'b0, 22'h0, 3'b000, 1'b0, 1'b0},
        '{3'b001, 32'h0040_6000, 22'd1, 32'h0000_0801, 32'h0000_0441, 1'b0,
          1'b1, 1'b0, 22'h0, 3'b000, 1'b0, 1'b0},
        '{3'b001, 32'h0040_7000, 22'd1, 32'h0000_0801, 32'h0000_04C5, 1'b0,
          1'b1, 1'b0, 22'h0, 3'b000, 1'b0, 1'b0},
        '{3'b001, 32'h0040_8000, 22'd1, 32'h0000_0801, 32'h0000_044D, 1'b0,
          1'b1, 1'b0, 22'h0, 3'b000, 1'b0, 1'b0},
        // pointer past the end of the RAM, aliasing a valid leaf in page 2
        '{3'b001, 32'h0100_0000, 22'd1, 32'h0000_1841, 32'h0000_04CF, 1'b0,
          1'b1, 1'b0, 22'h0, 3'b000, 1'b0, 1'b0},
        '{3'b111, 32'h0040_9000, 22'd1, 32'h0000_0801, 32'hFFFF_FCDF, 1'b1,
          1'b0, 1'b0, 22'h3FFFFF, 3'b111, 1'b0, 1'b1},
        '{3'b101, 32'h0040_A000, 22'd1, 32'h0000_0801, 32'h001D_DC63, 1'b1,
          1'b0, 1'b0, 22'h00777, 3'b100, 1'b1, 1'b0},
        '{3'b010, 32'h0041_0000, 22'd1, 32'h0000_0801, 32'h0A96_94DF, 1'b1,
          1'b0, 1'b0, 22'h2A5A5, 3'b111, 1'b0, 1'b1},
        '{3'b100, 32'hFFC0_0000, 22'd1, 32'hFFF0_00D7, 32'h0000_0000, 1'b1,
          1'b0, 1'b1, 22'h3FFC00, 3'b110, 1'b0, 1'b1}
    };

    PageWalkUnit uut (
        .clk   (clk),
        .rst   (rst),
        .rqs   (rqs),
        .res   (res),
        .pteWr (pteWr)
    );

    always #2 clk = ~clk;

    function automatic RqId highestBit(logic [`NUM_RQS-1:0] mask);
        RqId id;
        id = '0;
        for (int i = 0; i < `NUM_RQS; i++) begin
            if (mask[i]) begin
                id = RqId'(i);
            end
        end
        return id;
    endfunction

    function automatic void compareField(string name, logic [31:0] got, logic [31:0] expected);
        if (got !== expected) begin
            $display("ERROR %0t: %s is %0h, expected %0h", $time, name, got, expected);
            errors++;
        end
    endfunction

    // called on a falling edge, returns on the next one
    task automatic writeWord(logic [11:0] idx, Pte data);
        pteWr.en = 1'b1;
        pteWr.addr = idx;
        pteWr.data = data;
        @(negedge clk);
        pteWr.en = 1'b0;
    endtask

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        pteWr = '0;
        for (int i = 0; i < `NUM_RQS; i++) begin
            rqs[i] = '0;
        end
        seed = 32'h566c_f796;
        errors = 0;
        passed = 0;
        failed = 0;
        aborted = 1'b0;
        repeat (3) @(negedge clk);
        rst = 1'b0;

        for (int t = 0; t < NUM_TESTS && !aborted; t++) begin
            logic [`NUM_RQS-1:0] pending;
            RqId                 expId;
            logic [31:0]         rnd;
            int                  waitCycles;
            int                  errBefore;
            errBefore = errors;
            // level-1 entry in the root page, level-0 entry in page 2
            writeWord({tests[t].rootPpn[1:0], tests[t].va[31:22]}, tests[t].l1);
            writeWord({2'b10, tests[t].va[21:12]}, tests[t].l0);
            pending = tests[t].mask;
            for (int i = 0; i < `NUM_RQS; i++) begin
                rqs[i] = '{valid: pending[i], addr: tests[t].va, rootPpn: tests[t].rootPpn};
            end
            waitCycles = 0;
            while (pending != '0 && !aborted) begin
                @(negedge clk);
                waitCycles++;
                if (res.valid) begin
                    expId = highestBit(pending);
                    compareField("rqId", res.rqId, expId);
                    compareField("pageFault", res.pageFault, tests[t].fault);
                    compareField("vpn", res.vpn, tests[t].va[31:12]);
                    if (!tests[t].fault) begin
                        compareField("isSuperPage", res.isSuperPage, tests[t].superPage);
                        compareField("ppn", res.ppn, tests[t].ppn);
                        compareField("rwx", res.rwx, tests[t].rwx);
                        compareField("globl", res.globl, tests[t].globl);
                        compareField("user", res.user, tests[t].user);
                    end
                    pending[expId] = 1'b0;
                    rqs[expId].valid = 1'b0;
                    waitCycles = 0;
                end else if (!res.busy) begin
                    $display("ERROR %0t: busy low while a walk is pending", $time);
                    errors++;
                end
                // background writes to page 3, away from the tables
                rnd = $random(seed);
                pteWr.en = tests[t].noise && rnd[1:0] == 2'b00;
                pteWr.addr = {2'b11, rnd[13:4]};
                pteWr.data = $random(seed);
                if (waitCycles >= TIMEOUT) begin
                    $display("no result within %0d cycles in test %0d", TIMEOUT, t);
                    errors++;
                    aborted = 1'b1;
                end
            end
            pteWr.en = 1'b0;
            if (errors == errBefore) begin
                passed++;
                $display("test %0d ok", t);
            end else begin
                failed++;
                $display("test %0d had errors", t);
            end
        end

        $display("%0d tests ok, %0d with errors, %0d errors", passed, failed, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* PageWalkUnit.f */
+incdir+verilog
verilog/walkPkg.sv
verilog/PteLoadPort.sv
verilog/PageWalker.sv
verilog/PageWalkUnit.sv
bench/PageWalkUnit_chk.sv
bench/PageWalkUnitTb.sv

/* Makefile */
# Verilator build and run for the page table walk unit

VERILATOR ?= verilator
TOP       ?= PageWalkUnitTb
FILELIST  ?= PageWalkUnit.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
SOURCES   := $(wildcard verilog/*.sv verilog/*.svh bench/*.sv)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run $(TOP) and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(BUILD_DIR)/V$(TOP)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Result: FAILED" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "Result: PASSED" $(LOG); then echo "simulation did not finish"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
